// File: verilog/uart_string_macros.svh
/*
 * Shared constants for the framed string link.
 * UART_CLK_FREQ must match the real sys_clk. Baud rates that do not
 * divide it evenly are truncated to a whole number of clocks per bit.
 */
`ifndef UART_STRING_MACROS_SVH
`define UART_STRING_MACROS_SVH

// System clock in Hz
`define UART_CLK_FREQ 250_000_000

// Baud rate used when the top is not overridden
`define UART_BAUD_DEFAULT 115_200

// String buffer size in both directions
`define STR_MAX_BYTES 128
`define STR_WIDTH (`STR_MAX_BYTES * 8)

// Frame delimiter, ASCII '&'
`define FRAME_CHAR 8'h26

`endif

// File: verilog/uart_string_pkg.sv
/*
 * State types for the string framer, the deframer and the byte serializers.
 * Encodings are plain binary; nothing outside the RTL depends on them.
 */
`default_nettype none

package uart_string_pkg;

	// Transmit framer: "&&", payload, "&&", done
	typedef enum logic [2:0] {
		TX_IDLE    = 3'd0,
		TX_SIGN1   = 3'd1,  // First opening '&'
		TX_SIGN2   = 3'd2,  // Second opening '&'
		TX_CONTENT = 3'd3,  // Payload bytes
		TX_SIGN3   = 3'd4,  // First closing '&'
		TX_SIGN4   = 3'd5,  // Second closing '&'
		TX_FINISH  = 3'd6   // One-cycle done
	} tx_state_e;

	// Receive deframer, hunts for "&&" and stores until the next "&&"
	typedef enum logic [2:0] {
		RX_IDLE    = 3'd0,
		RX_SIGN1   = 3'd1,  // One '&' seen
		RX_SIGN2   = 3'd2,  // Opening pair complete
		RX_CONTENT = 3'd3,  // Storing payload
		RX_SIGN3   = 3'd4,  // '&' inside or closing
		RX_SIGN4   = 3'd5,  // Closing pair complete
		RX_FINISH  = 3'd6   // One-cycle done
	} rx_state_e;

	// Phase of one serial character
	typedef enum logic [1:0] {
		PH_IDLE  = 2'd0,
		PH_START = 2'd1,
		PH_DATA  = 2'd2,
		PH_STOP  = 2'd3
	} uart_phase_e;

endpackage

`default_nettype wire

// File: verilog/uart_tx.sv
/*
 * Byte serializer: start bit, 8 data bits LSB first, STOP_BITS stop bits.
 * tx_req is only legal while the serializer is idle; it is taken at once
 * and the start bit begins on the next edge. No parity.
 */
`include "uart_string_macros.svh"
`default_nettype none

module uart_tx #(
	parameter int BAUD_RATE = `UART_BAUD_DEFAULT,
	parameter int STOP_BITS = 2
) (
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	input  wire [7:0] tx_data,
	input  wire       tx_req,
	output logic      tx,
	output logic      tx_done
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = `UART_CLK_FREQ / BAUD_RATE;
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	uart_phase_e      phase;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       data_buf;
	logic             bit_end;

	assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));  // Last clock of a bit
	assign tx_done = (phase == PH_STOP) && bit_end && (bit_cnt == 4'(STOP_BITS - 1));

	always_ff @(posedge sys_clk) begin
		if (phase == PH_IDLE && tx_req)
			data_buf <= tx_data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase    <= PH_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;  // Line idles high
		end else begin
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (phase)
				PH_IDLE: begin
					baud_cnt <= '0;
					if (tx_req) begin
						phase <= PH_START;
						tx    <= 1'b0;  // Start bit
					end
				end
				PH_START: begin
					if (bit_end) begin
						phase   <= PH_DATA;
						bit_cnt <= '0;
						tx      <= data_buf[0];
					end
				end
				PH_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 4'd7) begin
							phase   <= PH_STOP;
							bit_cnt <= '0;
							tx      <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
							tx      <= data_buf[bit_cnt[2:0] + 3'd1];
						end
					end
				end
				PH_STOP: begin
					if (bit_end) begin
						if (tx_done) begin
							phase   <= PH_IDLE;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// The framer waits for tx_done before the next request
	a_req_when_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> (phase == PH_IDLE))
		else $error("uart_tx: request while a byte is in progress");

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
/*
 * Byte receiver, 8 data bits LSB first, no parity.
 * The start bit is confirmed at half a bit; data and stop bits are sampled
 * at their middle. A low stop bit drops the byte silently.
 * rx_vld is a one-cycle pulse with rx_data valid in the same cycle.
 */
`include "uart_string_macros.svh"
`default_nettype none

module uart_rx #(
	parameter int BAUD_RATE = `UART_BAUD_DEFAULT,
	parameter int STOP_BITS = 1
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        rx,
	output logic [7:0] rx_data,
	output logic       rx_vld
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = `UART_CLK_FREQ / BAUD_RATE;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	uart_phase_e      phase;
	logic [2:0]       rx_sync;  // Two sync stages plus previous value
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       shreg;
	logic             line;
	logic             fall;
	logic             half_end;
	logic             bit_end;
	logic             stop_ok;

	assign line     = rx_sync[1];
	assign fall     = rx_sync[2] & ~rx_sync[1];
	assign half_end = (baud_cnt == CNT_W'(HALF_BIT - 1));
	assign bit_end  = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));  // Middle of the bit after start
	assign stop_ok  = (phase == PH_STOP) && bit_end && line &&
		(bit_cnt == 4'(STOP_BITS - 1));

	always_ff @(posedge sys_clk) begin
		if (phase == PH_DATA && bit_end)
			shreg <= {line, shreg[7:1]};  // LSB arrives first
		if (stop_ok)
			rx_data <= shreg;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync  <= 3'b111;
			phase    <= PH_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[1:0], rx};
			rx_vld   <= stop_ok;
			baud_cnt <= baud_cnt + 1'b1;
			case (phase)
				PH_IDLE: begin
					baud_cnt <= '0;
					if (fall)
						phase <= PH_START;
				end
				PH_START: begin
					if (half_end) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						phase    <= line ? PH_IDLE : PH_DATA;  // Glitch goes back to hunting
					end
				end
				PH_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (bit_cnt == 4'd7) begin
							phase   <= PH_STOP;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end
				end
				PH_STOP: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (!line || stop_ok)
							phase <= PH_IDLE;  // Framing error or byte complete
						else
							bit_cnt <= bit_cnt + 4'd1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_string_handle.sv
/*
 * Framed string link: sends and receives "&&" payload "&&", 8N2 out, 8N1 in.
 * Payloads must not contain "&&" and must not end in '&'; nothing checks it.
 * A lone '&' is stored with the byte after it. Length 0 requests are ignored.
 * Received frames longer than STR_MAX_BYTES are not protected.
 */
`include "uart_string_macros.svh"
`default_nettype none

module uart_string_handle #(
	parameter int BAUD_RATE = `UART_BAUD_DEFAULT
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire [`STR_WIDTH-1:0]  tx_string,
	input  wire [7:0]             tx_length,
	input  wire                   tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,
	output logic [`STR_WIDTH-1:0] rx_string,
	output logic [7:0]            rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,
	input  wire                   uart_rx_port,
	output logic                  uart_tx_port
);
	import uart_string_pkg::*;

	tx_state_e             tx_state;
	rx_state_e             rx_state;

	logic [`STR_WIDTH-1:0] tx_string_buf;
	logic [7:0]            tx_length_buf;
	logic [7:0]            tx_byte_cnt;  // Payload bytes handed to uart_tx
	logic [9:0]            tx_slot;
	logic                  tx_take;
	logic                  byte_tx_req;
	logic [7:0]            byte_tx_data;
	logic                  byte_tx_done;

	logic [7:0]            byte_rx_data;
	logic                  byte_rx_vld;
	logic                  byte_rx_amp;
	logic                  byte_rx_other;
	logic [9:0]            rx_slot0;
	logic [9:0]            rx_slot1;

	assign tx_busy = (tx_state != TX_IDLE);
	assign tx_done = (tx_state == TX_FINISH);
	assign rx_busy = (rx_state != RX_IDLE);
	assign rx_done = (rx_state == RX_FINISH);

	assign tx_take = (tx_state == TX_IDLE) && tx_req && (tx_length != 8'd0);
	assign tx_slot = {tx_byte_cnt[6:0], 3'b000};

	// Transmit framer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state    <= TX_IDLE;
			tx_byte_cnt <= 8'd0;
			byte_tx_req <= 1'b0;
		end else begin
			byte_tx_req <= tx_take || (byte_tx_done && tx_state inside
				{TX_SIGN1, TX_SIGN2, TX_CONTENT, TX_SIGN3});
			case (tx_state)
				TX_IDLE: begin
					tx_byte_cnt <= 8'd0;
					if (tx_take)
						tx_state <= TX_SIGN1;
				end
				TX_SIGN1: if (byte_tx_done) tx_state <= TX_SIGN2;
				TX_SIGN2: begin
					if (byte_tx_done) begin
						tx_state    <= TX_CONTENT;
						tx_byte_cnt <= tx_byte_cnt + 8'd1;  // Byte 0 goes out next
					end
				end
				TX_CONTENT: begin
					if (byte_tx_done) begin
						if (tx_byte_cnt == tx_length_buf)
							tx_state <= TX_SIGN3;
						else
							tx_byte_cnt <= tx_byte_cnt + 8'd1;
					end
				end
				TX_SIGN3: if (byte_tx_done) tx_state <= TX_SIGN4;
				TX_SIGN4: if (byte_tx_done) tx_state <= TX_FINISH;
				TX_FINISH: tx_state <= TX_IDLE;
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// Latched request and the byte for the next uart_tx request
	always_ff @(posedge sys_clk) begin
		if (tx_take) begin
			tx_string_buf <= tx_string;
			tx_length_buf <= tx_length;
			byte_tx_data  <= `FRAME_CHAR;
		end else if (byte_tx_done) begin
			if (tx_state == TX_SIGN2 ||
					(tx_state == TX_CONTENT && tx_byte_cnt != tx_length_buf))
				byte_tx_data <= tx_string_buf[tx_slot +: 8];
			else
				byte_tx_data <= `FRAME_CHAR;  // Closing pair
		end
	end

	assign byte_rx_amp   = byte_rx_vld && (byte_rx_data == `FRAME_CHAR);
	assign byte_rx_other = byte_rx_vld && (byte_rx_data != `FRAME_CHAR);
	assign rx_slot0      = {rx_length[6:0], 3'b000};
	assign rx_slot1      = rx_slot0 + 10'd8;

	// Receive deframer, consumes every byte in the cycle it arrives
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state  <= RX_IDLE;
			rx_length <= 8'd0;
			rx_string <= '0;
		end else begin
			case (rx_state)
				RX_IDLE: if (byte_rx_amp) rx_state <= RX_SIGN1;
				RX_SIGN1: begin
					if (byte_rx_amp)
						rx_state <= RX_SIGN2;
					else if (byte_rx_other)
						rx_state <= RX_IDLE;  // Single '&' outside a frame
				end
				RX_SIGN2: begin
					rx_state  <= RX_CONTENT;
					rx_length <= 8'd0;
				end
				RX_CONTENT: begin
					if (byte_rx_amp) begin
						rx_state <= RX_SIGN3;
					end else if (byte_rx_other) begin
						rx_string[rx_slot0 +: 8] <= byte_rx_data;
						rx_length                <= rx_length + 8'd1;
					end
				end
				RX_SIGN3: begin
					if (byte_rx_amp) begin
						rx_state <= RX_SIGN4;
					end else if (byte_rx_other) begin
						// Lone '&' inside the payload, keep it with its follower
						rx_string[rx_slot0 +: 8] <= `FRAME_CHAR;
						rx_string[rx_slot1 +: 8] <= byte_rx_data;
						rx_length                <= rx_length + 8'd2;
						rx_state                 <= RX_CONTENT;
					end
				end
				RX_SIGN4: rx_state <= RX_FINISH;
				RX_FINISH: rx_state <= RX_IDLE;
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	uart_tx #(
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (2)
	) ins_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (byte_tx_data),
		.tx_req    (byte_tx_req),
		.tx        (uart_tx_port),
		.tx_done   (byte_tx_done)
	);

	uart_rx #(
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (1)
	) ins_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (byte_rx_data),
		.rx_vld    (byte_rx_vld)
	);

	// Caller must stay within the buffer
	a_tx_len: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_take |-> (tx_length <= 8'(`STR_MAX_BYTES)))
		else $error("tx_length above buffer size");

	// Every payload write lands inside rx_string
	a_rx_len: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		((rx_state == RX_CONTENT && byte_rx_other) |-> (rx_length < 8'(`STR_MAX_BYTES))) and
		((rx_state == RX_SIGN3 && byte_rx_other) |-> (rx_length <= 8'(`STR_MAX_BYTES - 2))))
		else $error("received frame overflows rx_string");

	a_tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("tx_done longer than one cycle");

	a_rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done longer than one cycle");

endmodule

`default_nettype wire

// File: tb/uart_string_checker.sv
/*
 * Watches the string link from outside at a fixed CLKS_PER_BIT.
 * Decodes uart_tx_port, counts done pulses and captures received frames.
 * The compare tasks take zero time and are called by the top between steps.
 */
`include "uart_string_macros.svh"
`default_nettype none

module uart_string_checker #(
	parameter int CLKS_PER_BIT = 10
) (
	input  wire                  sys_clk,
	input  wire                  sys_rst_n,
	input  wire                  tx_busy,
	input  wire                  tx_done,
	input  wire [`STR_WIDTH-1:0] rx_string,
	input  wire [7:0]            rx_length,
	input  wire                  rx_busy,
	input  wire                  rx_done,
	input  wire                  uart_tx_port,
	output int                   tests_run,
	output int                   tests_failed
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [7:0] AMP = 8'h26;

	string                 cur_name;
	int                    test_errs;
	logic [7:0]            line_q[$];  // Bytes decoded from uart_tx_port
	int                    tx_done_cnt;
	int                    rx_done_cnt;
	logic                  tx_done_last;
	logic                  tx_busy_seen;
	logic                  line_low_seen;
	logic                  rx_busy_seen;
	logic [7:0]            cap_len;
	logic [`STR_WIDTH-1:0] cap_str;  // rx_string as seen at rx_done

	task automatic report_value(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("Fail %s: %s expected %0h actual %0h", cur_name, what, exp_val, act_val);
		test_errs++;
	endtask

	task automatic report_text(input string msg);
		$display("Error in %s: %s", cur_name, msg);
		test_errs++;
	endtask

	task automatic match(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (act_val !== exp_val)
			report_value(what, exp_val, act_val);
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		test_errs = 0;
		line_q.delete();
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		tx_busy_seen = 1'b0;
		line_low_seen = 1'b0;
		rx_busy_seen = 1'b0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
			$display("Test %s failed with %0d errors", cur_name, test_errs);
		end else begin
			$display("Test %s passed", cur_name);
		end
	endtask

	task automatic inspect_reset_state();
		match("tx_busy", 32'd0, 32'(tx_busy));
		match("tx_done", 32'd0, 32'(tx_done));
		match("rx_busy", 32'd0, 32'(rx_busy));
		match("rx_done", 32'd0, 32'(rx_done));
		match("uart_tx_port", 32'd1, 32'(uart_tx_port));
		match("rx_length", 32'd0, 32'(rx_length));
		if (rx_string !== '0)
			report_text("rx_string is not all zero after reset");
	endtask

	// Expected line content is "&&", payload from byte 0 up, "&&"
	task automatic verify_tx_frame(input logic [`STR_WIDTH-1:0] data, input int len);
		logic [7:0] exp_q[$];
		exp_q.push_back(AMP);
		exp_q.push_back(AMP);
		for (int i = 0; i < len; i++)
			exp_q.push_back(data[i*8 +: 8]);
		exp_q.push_back(AMP);
		exp_q.push_back(AMP);
		match("frame byte count", 32'(exp_q.size()), 32'(line_q.size()));
		for (int i = 0; i < exp_q.size() && i < line_q.size(); i++) begin
			if (line_q[i] !== exp_q[i]) begin
				match($sformatf("frame byte %0d", i), 32'(exp_q[i]), 32'(line_q[i]));
				break;
			end
		end
		match("tx_done cycles", 32'd1, 32'(tx_done_cnt));
	endtask

	task automatic tx_ignored();
		if (tx_busy_seen)
			report_text("tx_busy rose for a zero-length request");
		if (line_low_seen || line_q.size() != 0)
			report_text("transmit line did not stay idle for a zero-length request");
		match("tx_done cycles", 32'd0, 32'(tx_done_cnt));
	endtask

	task automatic no_frame_started();
		if (rx_busy_seen || rx_done_cnt != 0)
			report_text("junk bytes before the frame started a frame");
	endtask

	task automatic verify_rx_frame(input logic [`STR_WIDTH-1:0] data, input int len);
		match("rx_done cycles", 32'd1, 32'(rx_done_cnt));
		match("rx_length", 32'(len), 32'(cap_len));
		for (int i = 0; i < len; i++) begin
			if (cap_str[i*8 +: 8] !== data[i*8 +: 8]) begin
				match($sformatf("rx_string byte %0d", i), 32'(data[i*8 +: 8]),
					32'(cap_str[i*8 +: 8]));
				break;
			end
		end
	endtask

	initial begin
		tests_run = 0;
		tests_failed = 0;
		test_errs = 0;
		cur_name = "none";
	end

	// Falling edge sampling, half a cycle away from every DUT update
	initial begin : monitor
		tx_done_last = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n) begin
				if (tx_busy)
					tx_busy_seen = 1'b1;
				if (!uart_tx_port)
					line_low_seen = 1'b1;
				if (rx_busy)
					rx_busy_seen = 1'b1;
				if (tx_done_last && tx_busy)
					report_text("tx_busy still high on the cycle after tx_done");
				if (tx_done)
					tx_done_cnt++;  // Also counts a stretched pulse
				if (rx_done) begin
					rx_done_cnt++;
					cap_len = rx_length;
					cap_str = rx_string;
				end
				tx_done_last = tx_done;
			end
		end
	end

	initial begin : tx_decoder
		logic [7:0] b;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);  // Middle of start bit
				if (uart_tx_port) begin
					report_text("start bit on the transmit line ended early");
				end else begin
					for (int i = 0; i < 8; i++) begin
						repeat (CLKS_PER_BIT) @(negedge sys_clk);
						b[i] = uart_tx_port;  // LSB first
					end
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					if (uart_tx_port)
						line_q.push_back(b);
					else
						report_text("low stop bit on the transmit line");
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_uart_string.sv
/*
 * Testbench for the framed string link at 10 clocks per bit.
 * Random payloads avoid "&&" and never end in '&'.
 * Comparison and per-test reporting happen in the checker.
 */
`include "uart_string_macros.svh"
`default_nettype none

module tb_uart_string;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLKS_PER_BIT = 10;
	localparam int NUM_TESTS = 52;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 132 * 12 * CLKS_PER_BIT * 2;
	localparam logic [7:0] AMP = 8'h26;

	logic                  sys_clk = 1'b0;
	logic                  sys_rst_n;
	logic [`STR_WIDTH-1:0] tx_string;
	logic [7:0]            tx_length;
	logic                  tx_req;
	logic                  uart_rx_port;
	wire                   tx_busy;
	wire                   tx_done;
	wire [`STR_WIDTH-1:0]  rx_string;
	wire [7:0]             rx_length;
	wire                   rx_busy;
	wire                   rx_done;
	wire                   uart_tx_port;
	int                    tests_run;
	int                    tests_failed;
	int                    cycle_cnt;
	integer                seed = 32'hf17b_2b34;

	always #2 sys_clk = ~sys_clk;

	uart_string_handle #(
		.BAUD_RATE (25_000_000)
	) dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	uart_string_checker #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) chk0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_tx_port (uart_tx_port),
		.tests_run    (tests_run),
		.tests_failed (tests_failed)
	);

	// Lands 1 ns after a rising edge
	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	function automatic logic [7:0] plain_byte();
		logic [7:0] b;
		do
			b = 8'($random(seed));
		while (b == AMP);
		return b;
	endfunction

	// Lone '&' never first, never last, never next to another '&'
	task automatic make_payload(input logic with_amp, output logic [`STR_WIDTH-1:0] data,
			output int len);
		logic [7:0] prev;
		data = '0;
		prev = 8'h00;
		len = with_amp ? ($random(seed) & 63) + 8 : ($random(seed) & 127) + 1;
		for (int i = 0; i < len; i++) begin
			if (with_amp && i > 0 && i < len - 1 && prev != AMP &&
					(i == 1 || ($random(seed) & 3) == 0))
				data[i*8 +: 8] = AMP;
			else
				data[i*8 +: 8] = plain_byte();
			prev = data[i*8 +: 8];
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		uart_rx_port = 1'b0;
		step(CLKS_PER_BIT);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port = b[i];
			step(CLKS_PER_BIT);
		end
		uart_rx_port = 1'b1;  // One stop bit
		step(CLKS_PER_BIT);
	endtask

	task automatic tx_frame_test(input int n);
		logic [`STR_WIDTH-1:0] data;
		int len;
		make_payload(1'b0, data, len);
		chk0.begin_test($sformatf("tx_frame_%0d", n));
		tx_string = data;
		tx_length = 8'(len);
		tx_req = 1'b1;
		step(1);
		tx_req = 1'b0;
		tx_string = {32{$random(seed)}};  // Inputs are latched, scramble them
		tx_length = 8'($random(seed));
		do
			@(negedge sys_clk);
		while (!tx_done);
		step(2);
		chk0.verify_tx_frame(data, len);
		chk0.end_test();
	endtask

	task automatic rx_frame_test(input string name, input logic [`STR_WIDTH-1:0] data,
			input int len, input int junk);
		chk0.begin_test(name);
		for (int j = 0; j < junk; j++)
			send_byte(plain_byte());
		if (junk > 0)
			chk0.no_frame_started();
		send_byte(AMP);
		send_byte(AMP);
		for (int i = 0; i < len; i++)
			send_byte(data[i*8 +: 8]);
		send_byte(AMP);
		send_byte(AMP);
		@(negedge sys_clk);
		while (rx_busy)
			@(negedge sys_clk);
		step(2);
		chk0.verify_rx_frame(data, len);
		chk0.end_test();
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [`STR_WIDTH-1:0] data;
		int len;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = 8'd0;
		tx_req = 1'b0;
		uart_rx_port = 1'b1;
		repeat (16) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		chk0.begin_test("reset_state");
		chk0.inspect_reset_state();
		chk0.end_test();

		chk0.begin_test("tx_zero_length");
		tx_string = {32{$random(seed)}};
		tx_req = 1'b1;
		step(1);
		tx_req = 1'b0;
		step(3 * CLKS_PER_BIT);  // Well past the 2-cycle start delay
		chk0.tx_ignored();
		chk0.end_test();

		for (int n = 0; n < 20; n++)
			tx_frame_test(n);
		for (int n = 0; n < 20; n++) begin
			make_payload(1'b0, data, len);
			rx_frame_test($sformatf("rx_frame_%0d", n), data, len, 0);
		end
		for (int n = 0; n < 5; n++) begin
			make_payload(1'b0, data, len);
			rx_frame_test($sformatf("rx_hunt_%0d", n), data, len, ($random(seed) & 7) + 1);
		end
		for (int n = 0; n < 5; n++) begin
			make_payload(1'b1, data, len);
			rx_frame_test($sformatf("rx_lone_amp_%0d", n), data, len, 0);
		end

		step(4);
		$display("Tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0 && tests_run == NUM_TESTS)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/uart_string_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_string_handle.sv
tb/uart_string_checker.sv
tb/tb_uart_string.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the string link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_uart_string -f verilog.f --Mdir obj_dir

./obj_dir/Vtb_uart_string > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
